//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = lsu_mem_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/lsu_mem_assertions.sv
// arbiter checks bound into memory_arbiter; needs assertion support enabled in the simulator
`timescale 1ns/100ps
`default_nettype none

module lsu_mem_assertions (
  input wire logic              clk,
  input wire logic              rst_n,
  input wire bus_pkg::bus_req_t mem_req,     // granted request toward memory
  input wire bus_pkg::bus_rsp_t mem_rsp,     // raw memory response
  input wire bus_pkg::bus_rsp_t scalar_rsp,
  input wire bus_pkg::bus_rsp_t vector_rsp,
  input wire cb_pkg::grant_e    grant_q      // held owner inside the arbiter
);

  // ==================================================
  // bus properties
  // ==================================================
  one_completion: assert property (@(posedge clk) disable iff (!rst_n)
    (scalar_rsp.busy || (grant_q == cb_pkg::GRANT_SCALAR)) &&
    (vector_rsp.busy || (grant_q == cb_pkg::GRANT_VECTOR)))  // only the held owner completes
    else $error("busy low reached a port that did not hold the grant");

  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ((mem_req.ren || mem_req.wen) && mem_rsp.busy) |=> $stable(mem_req))  // held until busy low
    else $error("memory request changed while busy was high");

  grant_reset: assert property (@(posedge clk)
    !rst_n |=> ((grant_q == cb_pkg::GRANT_NONE) && scalar_rsp.busy && vector_rsp.busy))
    else $error("bus not free with both ports busy after reset");

endmodule

bind memory_arbiter lsu_mem_assertions u_assertions (
  .clk       (clk),
  .rst_n     (rst_n),
  .mem_req   (mem_req),
  .mem_rsp   (mem_rsp),
  .scalar_rsp(scalar_rsp),
  .vector_rsp(vector_rsp),
  .grant_q   (grant_q)
);

`default_nettype wire

//--- bench/lsu_mem_tb.sv
// runs from the project root to find bench/lsu_mem_vectors.txt; vectors assume 16 cb entries and 256 words
`timescale 1ns/100ps
`default_nettype none

module lsu_mem_tb;

  localparam int NUM_CB_ENTRY = 16;
  localparam int MEM_LATENCY  = 2;
  localparam int MEM_WORDS    = 256;  // address 0x400 wraps to word 0
  localparam int IDX_W        = $clog2(NUM_CB_ENTRY);
  localparam int TIMEOUT      = 50;   // cycles allowed per transaction pair

  logic              clk;
  logic              rst_n;
  logic              retire;
  logic [IDX_W-1:0]  scalar_cb_index;
  logic [IDX_W-1:0]  vector_cb_index;
  bus_pkg::bus_req_t scalar_req;
  bus_pkg::bus_req_t vector_req;
  bus_pkg::bus_rsp_t scalar_rsp;
  bus_pkg::bus_rsp_t vector_rsp;

  int          fd;
  int          fields;
  int          vec_num;
  int          num_checks;
  int          num_errors;
  logic        hung;       // a port never completed, stop reading vectors
  string       line;
  logic [31:0] ret_cnt;    // retire pulses before the pair
  logic [31:0] s_idx;
  logic [31:0] v_idx;
  logic [31:0] s_op;       // 0 none, 1 read, 2 write
  logic [31:0] s_addr;
  logic [31:0] s_wdata;
  logic [31:0] s_be;
  logic [31:0] v_op;
  logic [31:0] v_addr;
  logic [31:0] v_wdata;
  logic [31:0] v_be;
  logic [31:0] exp_first;  // 0 single port, 1 scalar, 2 vector
  logic [31:0] s_exp;
  logic [31:0] v_exp;

  lsu_mem_top #(
    .NUM_CB_ENTRY(NUM_CB_ENTRY),
    .MEM_LATENCY (MEM_LATENCY),
    .MEM_WORDS   (MEM_WORDS)
  ) uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .retire         (retire),
    .scalar_cb_index(scalar_cb_index),
    .vector_cb_index(vector_cb_index),
    .scalar_req     (scalar_req),
    .vector_req     (vector_req),
    .scalar_rsp     (scalar_rsp),
    .vector_rsp     (vector_rsp)
  );

  always #2 clk = ~clk;  // 4 ns period

  // ==================================================
  // helpers
  // ==================================================
  function automatic bus_pkg::bus_req_t build_request(input logic [31:0] op, input logic [31:0] addr,
                                                      input logic [31:0] wdata, input logic [31:0] be);
    bus_pkg::bus_req_t req;
    req         = '0;
    req.addr    = addr;
    req.wdata   = wdata;
    req.byte_en = be[bus_pkg::BE_W-1:0];
    req.ren     = (op == 32'd1);
    req.wen     = (op == 32'd2);
    return req;
  endfunction

  task automatic apply_retires(input int count);
    if (count > 0) begin
      for (int i = 0; i < count; i++) begin
        @(posedge clk);
        retire <= 1'b1;  // tail steps once per high cycle
      end
      @(posedge clk);
      retire <= 1'b0;
    end
  endtask

  task automatic run_pair();
    int   waited;  // negedge samples so far
    int   first;   // 1 scalar, 2 vector, 0 nobody yet
    logic s_pend;
    logic v_pend;
    logic s_hit;
    logic v_hit;
    waited = 0;
    first  = 0;
    s_pend = (s_op != 32'd0);
    v_pend = (v_op != 32'd0);
    @(posedge clk);
    scalar_cb_index <= s_idx[IDX_W-1:0];
    vector_cb_index <= v_idx[IDX_W-1:0];
    scalar_req      <= build_request(s_op, s_addr, s_wdata, s_be);
    vector_req      <= build_request(v_op, v_addr, v_wdata, v_be);
    while ((s_pend || v_pend) && (waited < TIMEOUT)) begin
      @(negedge clk);  // responses settled mid-cycle
      s_hit = s_pend && !scalar_rsp.busy;
      v_hit = v_pend && !vector_rsp.busy;
      num_checks += 2;
      if (!s_pend && (scalar_rsp !== bus_pkg::RSP_IDLE)) begin
        num_errors++;
        $display("error vec%0d scalar_idle expected %h actual %h", vec_num, bus_pkg::RSP_IDLE,
                 scalar_rsp);
      end
      if (!v_pend && (vector_rsp !== bus_pkg::RSP_IDLE)) begin
        num_errors++;
        $display("error vec%0d vector_idle expected %h actual %h", vec_num, bus_pkg::RSP_IDLE,
                 vector_rsp);
      end
      if (s_hit && v_hit) begin
        num_errors++;
        $display("vector %0d: both ports completed in the same cycle", vec_num);
      end
      if (s_hit) begin
        if (first == 0) first = 1;
        if (s_op == 32'd1) begin
          num_checks++;
          if (scalar_rsp.rdata !== s_exp) begin
            num_errors++;
            $display("error vec%0d scalar_rdata expected %h actual %h", vec_num, s_exp,
                     scalar_rsp.rdata);
          end
        end
        if (v_op == 32'd0) begin
          num_checks++;  // lone access takes latency plus one
          if (waited != MEM_LATENCY + 1) begin
            num_errors++;
            $display("error vec%0d scalar_latency expected %0d actual %0d", vec_num,
                     MEM_LATENCY + 1, waited);
          end
        end
        s_pend = 1'b0;
      end
      if (v_hit) begin
        if (first == 0) first = 2;
        if (v_op == 32'd1) begin
          num_checks++;
          if (vector_rsp.rdata !== v_exp) begin
            num_errors++;
            $display("error vec%0d vector_rdata expected %h actual %h", vec_num, v_exp,
                     vector_rsp.rdata);
          end
        end
        if (s_op == 32'd0) begin
          num_checks++;
          if (waited != MEM_LATENCY + 1) begin
            num_errors++;
            $display("error vec%0d vector_latency expected %0d actual %0d", vec_num,
                     MEM_LATENCY + 1, waited);
          end
        end
        v_pend = 1'b0;
      end
      @(posedge clk);
      if (s_hit) scalar_req <= '0;  // drop after the busy-low cycle
      if (v_hit) vector_req <= '0;
      waited++;
    end
    if (s_pend) begin
      num_errors++;
      hung = 1'b1;
      $display("vector %0d: scalar port hung, busy stayed high for %0d cycles", vec_num, TIMEOUT);
    end
    if (v_pend) begin
      num_errors++;
      hung = 1'b1;
      $display("vector %0d: vector port hung, busy stayed high for %0d cycles", vec_num, TIMEOUT);
    end
    if (exp_first != 32'd0) begin
      num_checks++;
      if (first != exp_first) begin
        num_errors++;
        $display("error vec%0d first_finisher expected %0d actual %0d", vec_num, exp_first, first);
      end
    end
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    retire          = 1'b0;
    scalar_cb_index = '0;
    vector_cb_index = '0;
    scalar_req      = '0;
    vector_req      = '0;
    vec_num         = 0;
    num_checks      = 0;
    num_errors      = 0;
    hung            = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    fd = $fopen("bench/lsu_mem_vectors.txt", "r");
    if (fd == 0) begin
      num_errors++;
      $display("could not open bench/lsu_mem_vectors.txt");
    end else begin
      while (!hung && ($fgets(line, fd) != 0)) begin
        if ((line.len() < 2) || (line[0] == "#")) continue;  // blank or column notes
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", ret_cnt, s_idx,
                         v_idx, s_op, s_addr, s_wdata, s_be, v_op, v_addr, v_wdata, v_be,
                         exp_first, s_exp, v_exp);
        if (fields != 14) begin
          num_errors++;
          $display("vector line after %0d is malformed, found %0d fields", vec_num, fields);
          continue;
        end
        vec_num++;
        apply_retires(ret_cnt);
        run_pair();
      end
      $fclose(fd);
    end
    if (vec_num == 0) begin
      num_errors++;
      $display("no vectors were run");
    end
    $display("vectors %0d checks %0d errors %0d", vec_num, num_checks, num_errors);
    if (num_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/lsu_mem_vectors.txt
# hex columns: retire s_idx v_idx s_op s_addr s_wdata s_be v_op v_addr v_wdata v_be first s_exp v_exp
# op 0 none 1 read 2 write; first 0 single port 1 scalar 2 vector; retire pulses apply before the pair
0 1 0 2 00000010 a5a5a5a5 f 0 00000000 00000000 0 0 00000000 00000000
0 1 0 1 00000010 00000000 0 0 00000000 00000000 0 0 a5a5a5a5 00000000
0 1 0 2 00000010 11223344 5 0 00000000 00000000 0 0 00000000 00000000
0 1 0 1 00000010 00000000 0 0 00000000 00000000 0 0 a522a544 00000000
0 0 3 0 00000000 00000000 0 2 00000020 cafef00d f 0 00000000 00000000
0 0 3 0 00000000 00000000 0 1 00000020 00000000 0 0 00000000 cafef00d
0 2 5 1 00000010 00000000 0 2 00000040 deadbeef f 1 a522a544 00000000
0 7 3 2 00000040 00001234 3 1 00000040 00000000 0 2 00000000 deadbeef
0 7 3 1 00000040 00000000 0 0 00000000 00000000 0 0 dead1234 00000000
0 4 4 1 00000020 00000000 0 2 00000020 01020304 f 2 01020304 00000000
0 1 3 1 00000010 00000000 0 1 00000020 00000000 0 1 a522a544 01020304
2 1 3 1 00000010 00000000 0 1 00000020 00000000 0 2 a522a544 01020304
e 1 3 1 00000010 00000000 0 1 00000020 00000000 0 1 a522a544 01020304
0 0 0 2 00000400 5a5a0001 f 0 00000000 00000000 0 0 00000000 00000000
0 0 0 0 00000000 00000000 0 1 00000000 00000000 0 0 00000000 5a5a0001
f 0 e 1 00000000 00000000 0 1 00000010 00000000 0 1 5a5a0001 a522a544
1 f 0 2 00000010 0badcafe f 1 00000010 00000000 0 2 00000000 a522a544
0 f 0 0 00000000 00000000 0 1 00000010 00000000 0 0 00000000 0badcafe

//--- build.f
logic/bus_pkg.sv
logic/cb_pkg.sv
logic/cb_tail_tracker.sv
logic/memory_arbiter.sv
logic/wait_state_memory.sv
logic/lsu_mem_top.sv
bench/lsu_mem_assertions.sv
bench/lsu_mem_tb.sv

//--- logic/bus_pkg.sv
// generic memory bus fields; word-aligned accesses only, no error response, rdata valid only while busy is low
`default_nettype none

package bus_pkg;

  // ==================================================
  // widths
  // ==================================================
  localparam int ADDR_W = 32;          // byte address
  localparam int DATA_W = 32;          // one word per beat
  localparam int BE_W   = DATA_W / 8;  // one enable per byte lane

  // ==================================================
  // master to slave
  // ==================================================
  typedef struct packed {
    logic [ADDR_W-1:0] addr;     // byte address, low two bits ignored
    logic [DATA_W-1:0] wdata;    // write payload
    logic [BE_W-1:0]   byte_en;  // lane select for writes
    logic              ren;      // read request, held until busy low
    logic              wen;      // write request, held until busy low
  } bus_req_t;                   // 70 bits

  // ==================================================
  // slave to master
  // ==================================================
  typedef struct packed {
    logic [DATA_W-1:0] rdata;    // read data, valid in the busy-low cycle
    logic              busy;     // low for exactly one cycle per access
  } bus_rsp_t;                   // 33 bits

  // idle response seen by a port that does not own the bus
  localparam bus_rsp_t RSP_IDLE = '{rdata: '0, busy: 1'b1};

endpackage

`default_nettype wire

//--- logic/cb_pkg.sv
// arbitration and memory-model encodings; exactly two requesters, states cover a single outstanding access
`default_nettype none

package cb_pkg;

  // ==================================================
  // cache bus owner
  // ==================================================
  typedef enum logic [1:0] {
    GRANT_NONE   = 2'd0,  // bus free, arbitration open
    GRANT_SCALAR = 2'd1,  // scalar lsu owns the bus
    GRANT_VECTOR = 2'd2   // vector lsu owns the bus
  } grant_e;

  // ==================================================
  // wait-state memory fsm
  // ==================================================
  typedef enum logic [1:0] {
    MEM_IDLE = 2'd0,  // waiting for ren or wen
    MEM_WAIT = 2'd1,  // counting wait states
    MEM_DONE = 2'd2   // busy low for one cycle
  } mem_state_e;

endpackage

`default_nettype wire

//--- logic/cb_tail_tracker.sv
// completion-buffer tail only, no head or full tracking; one retire per cycle at most
`timescale 1ns/100ps
`default_nettype none

module cb_tail_tracker #(
  parameter int NUM_CB_ENTRY = 16  // power of two, so the pointer wraps by overflow
) (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            retire,
  output logic [$clog2(NUM_CB_ENTRY)-1:0]      cb_tail_index
);

  localparam int IDX_W = $clog2(NUM_CB_ENTRY);

  logic [IDX_W-1:0] tail_q;  // oldest live entry
  logic [IDX_W-1:0] tail_d;  // tail after this cycle's retire

  // ==================================================
  // tail pointer
  // ==================================================
  always_comb begin
    tail_d = tail_q;
    if (retire) begin
      tail_d = tail_q + IDX_W'(1);  // step past the retired entry, wraps at depth
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tail_q <= '0;  // empty buffer starts at entry 0
    end else begin
      tail_q <= tail_d;
    end
  end

  assign cb_tail_index = tail_q;  // age reference for the arbiter

endmodule

`default_nettype wire

//--- logic/lsu_mem_top.sv
// data-memory path: tail tracker, two-port age arbiter and wait-state memory; ports follow the generic bus hold rule
`timescale 1ns/100ps
`default_nettype none

module lsu_mem_top #(
  parameter int NUM_CB_ENTRY = 16,  // power of two
  parameter int MEM_LATENCY  = 2,   // minimum 1
  parameter int MEM_WORDS    = 256  // power of two
) (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            retire,           // one pulse per retired entry
  input  wire logic [$clog2(NUM_CB_ENTRY)-1:0] scalar_cb_index,
  input  wire logic [$clog2(NUM_CB_ENTRY)-1:0] vector_cb_index,
  input  wire bus_pkg::bus_req_t               scalar_req,
  input  wire bus_pkg::bus_req_t               vector_req,
  output bus_pkg::bus_rsp_t                    scalar_rsp,
  output bus_pkg::bus_rsp_t                    vector_rsp
);

  logic [$clog2(NUM_CB_ENTRY)-1:0] cb_tail_index;  // age reference
  bus_pkg::bus_req_t               mem_req;        // arbiter to memory
  bus_pkg::bus_rsp_t               mem_rsp;        // memory to arbiter

  // ==================================================
  // blocks
  // ==================================================
  cb_tail_tracker #(.NUM_CB_ENTRY(NUM_CB_ENTRY)) u_tail (
    .clk          (clk),
    .rst_n        (rst_n),
    .retire       (retire),
    .cb_tail_index(cb_tail_index)
  );

  memory_arbiter #(.NUM_CB_ENTRY(NUM_CB_ENTRY)) u_arb (
    .clk            (clk),
    .rst_n          (rst_n),
    .cb_tail_index  (cb_tail_index),
    .scalar_cb_index(scalar_cb_index),
    .vector_cb_index(vector_cb_index),
    .scalar_req     (scalar_req),
    .vector_req     (vector_req),
    .scalar_rsp     (scalar_rsp),
    .vector_rsp     (vector_rsp),
    .mem_req        (mem_req),
    .mem_rsp        (mem_rsp)
  );

  wait_state_memory #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) u_mem (
    .clk  (clk),
    .rst_n(rst_n),
    .req  (mem_req),
    .rsp  (mem_rsp)
  );

endmodule

`default_nettype wire

//--- logic/memory_arbiter.sv
// picks the access older relative to the cb tail, vector wins ties; grant held until busy low, two ports only
`timescale 1ns/100ps
`default_nettype none

module memory_arbiter #(
  parameter int NUM_CB_ENTRY = 16  // power of two
) (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic [$clog2(NUM_CB_ENTRY)-1:0]   cb_tail_index,
  input  wire logic [$clog2(NUM_CB_ENTRY)-1:0]   scalar_cb_index,
  input  wire logic [$clog2(NUM_CB_ENTRY)-1:0]   vector_cb_index,
  input  wire bus_pkg::bus_req_t                 scalar_req,
  input  wire bus_pkg::bus_req_t                 vector_req,
  output bus_pkg::bus_rsp_t                      scalar_rsp,
  output bus_pkg::bus_rsp_t                      vector_rsp,
  output bus_pkg::bus_req_t                      mem_req,
  input  wire bus_pkg::bus_rsp_t                 mem_rsp
);

  localparam int IDX_W = $clog2(NUM_CB_ENTRY);

  logic [IDX_W-1:0] scalar_dist;  // age of scalar access, 0 is oldest
  logic [IDX_W-1:0] vector_dist;  // age of vector access
  logic             scalar_act;   // scalar port has ren or wen
  logic             vector_act;   // vector port has ren or wen
  cb_pkg::grant_e   grant_pick;   // fresh decision from ages
  cb_pkg::grant_e   grant_cur;    // owner in this cycle
  cb_pkg::grant_e   grant_q;      // owner carried across edges

  // ==================================================
  // age compare
  // ==================================================
  assign scalar_dist = scalar_cb_index - cb_tail_index;  // wraps modulo depth
  assign vector_dist = vector_cb_index - cb_tail_index;
  assign scalar_act  = scalar_req.ren | scalar_req.wen;
  assign vector_act  = vector_req.ren | vector_req.wen;

  always_comb begin
    grant_pick = cb_pkg::GRANT_NONE;
    if (scalar_act && (!vector_act || (scalar_dist < vector_dist))) begin
      grant_pick = cb_pkg::GRANT_SCALAR;  // strictly older or alone
    end else if (vector_act) begin
      grant_pick = cb_pkg::GRANT_VECTOR;  // older, tied, or alone
    end
  end

  // a held grant overrides the age decision until completion
  assign grant_cur = (grant_q != cb_pkg::GRANT_NONE) ? grant_q : grant_pick;

  // ==================================================
  // grant hold
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_q <= cb_pkg::GRANT_NONE;
    end else if (!mem_rsp.busy) begin
      grant_q <= cb_pkg::GRANT_NONE;  // access done, reopen next cycle
    end else begin
      grant_q <= grant_cur;           // latch the new owner or keep the old one
    end
  end

  // ==================================================
  // steering
  // ==================================================
  always_comb begin
    mem_req    = '0;                 // nothing reaches memory by default
    scalar_rsp = bus_pkg::RSP_IDLE;  // loser sees busy 1, rdata 0
    vector_rsp = bus_pkg::RSP_IDLE;
    case (grant_cur)
      cb_pkg::GRANT_SCALAR: begin
        mem_req    = scalar_req;
        scalar_rsp = mem_rsp;
      end
      cb_pkg::GRANT_VECTOR: begin
        mem_req    = vector_req;
        vector_rsp = mem_rsp;
      end
      default: begin
        mem_req = '0;  // bus idle
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/wait_state_memory.sv
// cache stand-in: word store with MEM_LATENCY wait states, MEM_WORDS a power of two, addresses wrap, no errors
`timescale 1ns/100ps
`default_nettype none

module wait_state_memory #(
  parameter int MEM_LATENCY = 2,   // minimum 1
  parameter int MEM_WORDS   = 256  // power of two
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire bus_pkg::bus_req_t req,
  output bus_pkg::bus_rsp_t      rsp
);

  localparam int WIDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W  = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  logic [bus_pkg::DATA_W-1:0] mem [MEM_WORDS];  // word array
  cb_pkg::mem_state_e         state_q;
  logic [CNT_W-1:0]           cnt_q;            // wait cycles already spent
  logic [WIDX_W-1:0]          idx_q;            // latched word index
  logic [bus_pkg::DATA_W-1:0] wdata_q;          // latched write payload
  logic [bus_pkg::BE_W-1:0]   be_q;             // latched lane enables
  logic                       wen_q;            // access is a write
  logic                       accept;           // request taken this cycle

  assign accept = (state_q == cb_pkg::MEM_IDLE) && (req.ren || req.wen);

  // ==================================================
  // fsm
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= cb_pkg::MEM_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        cb_pkg::MEM_IDLE: if (accept) begin
          state_q <= cb_pkg::MEM_WAIT;
          cnt_q   <= '0;
        end
        cb_pkg::MEM_WAIT: if (cnt_q == CNT_W'(MEM_LATENCY - 1)) begin
          state_q <= cb_pkg::MEM_DONE;  // last wait state spent
        end else begin
          cnt_q <= cnt_q + CNT_W'(1);
        end
        default: state_q <= cb_pkg::MEM_IDLE;  // done lasts one cycle
      endcase
    end
  end

  // payload captured once, master holds it anyway
  always_ff @(posedge clk) begin
    if (accept) begin
      idx_q   <= req.addr[WIDX_W+1:2];  // drop byte offset, upper bits wrap
      wdata_q <= req.wdata;
      be_q    <= req.byte_en;
      wen_q   <= req.wen;
    end
  end

  // ==================================================
  // storage
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem[w] <= '0;  // model comes up zeroed
      end
    end else if ((state_q == cb_pkg::MEM_DONE) && wen_q) begin
      for (int b = 0; b < bus_pkg::BE_W; b++) begin
        if (be_q[b]) begin
          mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];  // masked lanes keep old bytes
        end
      end
    end
  end

  // read word shows only in the completion cycle
  assign rsp.busy  = (state_q != cb_pkg::MEM_DONE);
  assign rsp.rdata = ((state_q == cb_pkg::MEM_DONE) && !wen_q) ? mem[idx_q] : '0;

endmodule

`default_nettype wire
